//--- bench/seq_testdata.txt
# issue op vd vs1 vs2 use_vd use_vs1 use_vs2 id hz_vs1 hz_vs2 hz_vd (masks hex)
# stall cycles op vd vs1 vs2 use_vd use_vs1 use_vs2 | done unit id | bp cycles
# table row mask_hex | idle flag | op 0 add 1 sub 2 and 3 or 4 mul 5 macc 6 load 7 store
# unit 0 alu 1 mul 2 load 3 store
idle 1
# Independent instructions from reset
issue 0 1 2 3 1 1 1 0 00 00 00
issue 4 4 5 6 1 1 1 1 00 00 00
issue 6 7 8 0 1 1 0 2 00 00 00
idle 0
table 0 00
# RAW on both sources
issue 1 9 1 4 1 1 1 3 01 02 00
table 3 03
# WAR, then WAR plus WAW on v2
issue 5 2 10 11 1 1 1 4 00 00 01
issue 6 2 12 0 1 1 0 5 00 00 11
table 5 11
# Producers retire
done 0 0
table 3 02
table 4 00
table 5 10
done 1 1
table 3 00
done 0 3
issue 1 9 1 4 1 1 1 0 00 00 00
table 0 00
# Load queue full, ALU still open
stall 4 6 13 14 0 1 1 0
issue 0 15 16 17 1 1 1 1 00 00 00
done 2 2
issue 6 13 14 0 1 1 0 2 00 00 00
# Back-pressure on the issue port
bp 3
issue 4 18 15 13 1 1 1 3 02 04 00
table 3 06
issue 7 0 18 0 0 1 0 6 08 00 00
table 6 08
# All IDs in flight, then reuse of ID 3
issue 7 0 19 0 0 1 0 7 00 00 00
stall 3 0 20 21 22 1 1 1
done 1 3
table 6 00
issue 4 20 21 22 1 1 1 3 00 00 00
table 3 00
# Drain
done 0 0
done 0 1
done 2 2
done 1 3
done 1 4
done 2 5
done 3 6
done 3 7
idle 1

//--- bench/tb_vector_sequencer.sv
// Self-checking testbench for the vector instruction sequencer.
// Replays the command list in bench/seq_testdata.txt against the DUT and
// checks issued IDs, hazard masks, handshake, table rows and the idle flag
`timescale 1ns/1ps

module tb_vector_sequencer import seq_pkg::*; ();

  localparam int    ClkPeriod     = 4;
  localparam int    CyclesPerLine = 50;
  localparam string DataFile      = "bench/seq_testdata.txt";
  // Default depth of the DUT queues
  localparam int    QueueDepth    = 2;

  logic          clk_i;
  logic          rst_ni;
  seq_req_t      req_i;
  logic          req_valid_i;
  logic          req_ready_o;
  issue_req_t    issue_req_o;
  logic          issue_valid_o;
  logic          issue_ready_i;
  unit_done_t    unit_done_i;
  hazard_table_t global_hazard_table_o;
  logic          idle_o;

  int          fd;
  int unsigned line_total;
  // Cycles the next issued request is held under back-pressure
  int          hold_cycles;
  // Outstanding instructions per unit, from the issue and done commands
  int unsigned queued [NrUnits];

  vector_sequencer dut (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .req_i                (req_i),
    .req_valid_i          (req_valid_i),
    .req_ready_o          (req_ready_o),
    .issue_req_o          (issue_req_o),
    .issue_valid_o        (issue_valid_o),
    .issue_ready_i        (issue_ready_i),
    .unit_done_i          (unit_done_i),
    .global_hazard_table_o(global_hazard_table_o),
    .idle_o               (idle_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Budget grows with the length of the command list
  initial begin : watchdog
    wait (line_total != 0);
    repeat (line_total * CyclesPerLine) @(posedge clk_i);
    abort_run("Watchdog expired before the command list finished");
  end

  ////////////////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("Testbench failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic abort_run(input string why);
    $display("%s at time %0t", why, $time);
    stop_with_failure();
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("mismatch at time %0t: %s expected %0h actual %0h", $time, name, expected,
             actual);
    stop_with_failure();
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Unit model
  ////////////////////////////////////////////////////////////////////////

  // Opcodes 0 to 3 run on the ALU, 4 and 5 on the multiplier, 6 load, 7 store
  function automatic int unit_for_op(input int op);
    if (op < 4) begin
      return 0;
    end else if (op < 6) begin
      return 1;
    end
    return op - 4;
  endfunction

  // First opcode of a unit whose queue still has room, or -1 if none has
  function automatic int op_with_room();
    for (int u = 0; u < NrUnits; u++) begin
      if (queued[u] < QueueDepth) begin
        return (u < 2) ? 4 * u : u + 4;
      end
    end
    return -1;
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Data file access
  ////////////////////////////////////////////////////////////////////////

  task automatic count_lines();
    logic [8*256-1:0] text;
    int               cnt_fd;
    int unsigned      cnt;
    cnt = 0;
    cnt_fd = $fopen(DataFile, "r");
    if (cnt_fd == 0) begin
      abort_run("Cannot open the data file");
    end
    while (!$feof(cnt_fd)) begin
      if ($fgets(text, cnt_fd) != 0) begin
        cnt++;
      end
    end
    $fclose(cnt_fd);
    if (cnt == 0) begin
      abort_run("Data file holds no commands");
    end
    line_total = cnt;
  endtask

  // Request fields: op vd vs1 vs2 use_vd use_vs1 use_vs2
  task automatic read_req(output seq_req_t req);
    int op, vd, vs1, vs2, use_vd, use_vs1, use_vs2;
    int code;
    code = $fscanf(fd, "%d %d %d %d %d %d %d", op, vd, vs1, vs2, use_vd, use_vs1, use_vs2);
    if (code != 7) begin
      abort_run("Malformed request fields in the data file");
    end
    req.op      = op_e'(op);
    req.vd      = vreg_t'(vd);
    req.vs1     = vreg_t'(vs1);
    req.vs2     = vreg_t'(vs2);
    req.use_vd  = use_vd[0];
    req.use_vs1 = use_vs1[0];
    req.use_vs2 = use_vs2[0];
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Commands
  ////////////////////////////////////////////////////////////////////////

  task automatic issue_insn(input seq_req_t req, input int exp_id, input int hz1,
                            input int hz2, input int hzd);
    issue_req_t held;
    seq_req_t   probe;
    vid_mask_t  exp_row;
    int         exp_unit;
    int         probe_op;
    exp_row  = vid_mask_t'(hz1 | hz2 | hzd);
    exp_unit = unit_for_op(req.op);
    @(posedge clk_i);
    req_i       <= req;
    req_valid_i <= 1'b1;
    // Ready is combinational, so the offer is taken at the next edge
    @(negedge clk_i);
    assert (req_ready_o == 1'b1) else report_mismatch("req_ready_o", 1, req_ready_o);
    assert (issue_valid_o == 1'b0) else report_mismatch("issue_valid_o", 0, issue_valid_o);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    queued[exp_unit]++;
    // Issue register loaded one cycle after acceptance
    @(negedge clk_i);
    assert (issue_valid_o == 1'b1) else report_mismatch("issue_valid_o", 1, issue_valid_o);
    assert (issue_req_o.id == vid_t'(exp_id))
      else report_mismatch("issue_req_o.id", exp_id, issue_req_o.id);
    assert (issue_req_o.op == req.op) else report_mismatch("issue_req_o.op", req.op,
                                                            issue_req_o.op);
    assert (issue_req_o.unit == unit_e'(exp_unit))
      else report_mismatch("issue_req_o.unit", exp_unit, issue_req_o.unit);
    assert (issue_req_o.vd == req.vd) else report_mismatch("issue_req_o.vd", req.vd,
                                                            issue_req_o.vd);
    assert (issue_req_o.vs1 == req.vs1)
      else report_mismatch("issue_req_o.vs1", req.vs1, issue_req_o.vs1);
    assert (issue_req_o.vs2 == req.vs2)
      else report_mismatch("issue_req_o.vs2", req.vs2, issue_req_o.vs2);
    assert ({issue_req_o.use_vd, issue_req_o.use_vs1, issue_req_o.use_vs2} ==
            {req.use_vd, req.use_vs1, req.use_vs2})
      else report_mismatch("issue_req_o use flags", {req.use_vd, req.use_vs1, req.use_vs2},
                           {issue_req_o.use_vd, issue_req_o.use_vs1, issue_req_o.use_vs2});
    assert (issue_req_o.hazard_vs1 == vid_mask_t'(hz1))
      else report_mismatch("issue_req_o.hazard_vs1", hz1, issue_req_o.hazard_vs1);
    assert (issue_req_o.hazard_vs2 == vid_mask_t'(hz2))
      else report_mismatch("issue_req_o.hazard_vs2", hz2, issue_req_o.hazard_vs2);
    assert (issue_req_o.hazard_vd == vid_mask_t'(hzd))
      else report_mismatch("issue_req_o.hazard_vd", hzd, issue_req_o.hazard_vd);
    // New table row lists every producer
    assert (global_hazard_table_o[exp_id] == exp_row)
      else report_mismatch("global_hazard_table_o row", exp_row,
                           global_hazard_table_o[exp_id]);
    if (hold_cycles > 0) begin
      held = issue_req_o;
      // Probe a unit with room so that only the hold can keep ready low
      probe_op = op_with_room();
      if (probe_op < 0) begin
        abort_run("No unit has queue room for the back-pressure probe");
      end
      probe    = req;
      probe.op = op_e'(probe_op);
      repeat (hold_cycles) begin
        @(posedge clk_i);
        req_i <= probe;
        @(negedge clk_i);
        assert (issue_valid_o == 1'b1)
          else report_mismatch("issue_valid_o", 1, issue_valid_o);
        assert (issue_req_o == held) else report_mismatch("issue_req_o", held, issue_req_o);
        assert (req_ready_o == 1'b0) else report_mismatch("req_ready_o", 0, req_ready_o);
      end
      // Units take the held request at the edge after release
      @(posedge clk_i);
      issue_ready_i <= 1'b1;
      hold_cycles = 0;
    end
  endtask

  // Offer a request that must not be accepted
  task automatic check_stall(input seq_req_t req, input int cycles);
    @(posedge clk_i);
    req_i       <= req;
    req_valid_i <= 1'b1;
    repeat (cycles) begin
      @(negedge clk_i);
      assert (req_ready_o == 1'b0) else report_mismatch("req_ready_o", 0, req_ready_o);
      @(posedge clk_i);
    end
    req_valid_i <= 1'b0;
  endtask

  task automatic pulse_done(input int unit, input int id);
    unit_done_t pulse;
    pulse = '0;
    pulse.unit[unit].valid = 1'b1;
    pulse.unit[unit].vid   = vid_t'(id);
    @(posedge clk_i);
    unit_done_i <= pulse;
    @(posedge clk_i);
    unit_done_i <= '0;
    queued[unit]--;
  endtask

  task automatic apply_backpressure(input int cycles);
    @(posedge clk_i);
    issue_ready_i <= 1'b0;
    hold_cycles = cycles;
  endtask

  task automatic check_table_row(input int row, input int expected);
    @(posedge clk_i);
    @(negedge clk_i);
    assert (global_hazard_table_o[row] == vid_mask_t'(expected))
      else report_mismatch("global_hazard_table_o row", expected, global_hazard_table_o[row]);
  endtask

  task automatic check_idle(input int expected);
    @(posedge clk_i);
    @(negedge clk_i);
    assert (idle_o == expected[0]) else report_mismatch("idle_o", expected, idle_o);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////

  initial begin : main
    string            cmd;
    seq_req_t         req;
    logic [8*256-1:0] rest;
    int               code;
    int               arg_a;
    int               arg_b;
    int               hz1, hz2, hzd;
    rst_ni        = 1'b0;
    req_i         = '0;
    req_valid_i   = 1'b0;
    issue_ready_i = 1'b1;
    unit_done_i   = '0;
    hold_cycles   = 0;
    line_total    = 0;
    foreach (queued[u]) begin
      queued[u] = 0;
    end
    count_lines();
    fd = $fopen(DataFile, "r");
    if (fd == 0) begin
      abort_run("Cannot open the data file");
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);
      end else if (cmd == "issue") begin
        read_req(req);
        code = $fscanf(fd, "%d %h %h %h", arg_a, hz1, hz2, hzd);
        if (code != 4) begin
          abort_run("Malformed issue expectations in the data file");
        end
        issue_insn(req, arg_a, hz1, hz2, hzd);
      end else if (cmd == "stall") begin
        code = $fscanf(fd, "%d", arg_a);
        read_req(req);
        check_stall(req, arg_a);
      end else if (cmd == "done") begin
        code = $fscanf(fd, "%d %d", arg_a, arg_b);
        pulse_done(arg_a, arg_b);
      end else if (cmd == "bp") begin
        code = $fscanf(fd, "%d", arg_a);
        apply_backpressure(arg_a);
      end else if (cmd == "table") begin
        code = $fscanf(fd, "%d %h", arg_a, arg_b);
        check_table_row(arg_a, arg_b);
      end else if (cmd == "idle") begin
        code = $fscanf(fd, "%d", arg_a);
        check_idle(arg_a);
      end else begin
        abort_run({"Unknown command in the data file: ", cmd});
      end
    end
    $fclose(fd);
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- vector_sequencer.f
verilog/seq_pkg.sv
verilog/vid_allocator.sv
verilog/vreg_tracker.sv
verilog/unit_queue_counters.sv
verilog/issue_ctrl.sv
verilog/vector_sequencer.sv
bench/tb_vector_sequencer.sv

//--- verilog/issue_ctrl.sv
// Issue control of the sequencer.
// Decides whether the dispatcher request is taken, registers the issued
// instruction and holds it while the units stall, and keeps the global
// table of dependencies between running instructions
`timescale 1ns/1ps

module issue_ctrl import seq_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Dispatcher handshake
  input  seq_req_t           req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output logic               accept_o,
  // ID allocator
  input  vid_t               new_id_i,
  input  logic               id_full_i,
  // Queue room per unit
  input  logic [NrUnits-1:0] unit_room_i,
  input  vid_mask_t          running_i,
  // Dependencies of the incoming instruction
  input  vid_mask_t          hazard_vs1_i,
  input  vid_mask_t          hazard_vs2_i,
  input  vid_mask_t          hazard_vd_i,
  // Functional unit side
  output issue_req_t         issue_req_o,
  output logic               issue_valid_o,
  input  logic               issue_ready_i,
  output hazard_table_t      global_hazard_table_o
);

  issue_req_t    issue_req_d, issue_req_q;
  logic          issue_valid_d, issue_valid_q;
  hazard_table_t hazard_table_d, hazard_table_q;
  // Issued request not yet taken
  logic          hold;
  unit_e         req_unit;

  //////////////////////////////////////////////////////////////////////
  // Accept decision
  //////////////////////////////////////////////////////////////////////

  assign req_unit    = unit_of(req_i.op);
  assign hold        = issue_valid_q && !issue_ready_i;
  assign req_ready_o = !hold && !id_full_i && unit_room_i[req_unit];
  assign accept_o    = req_valid_i && req_ready_o;

  // Issue register, cleared when nothing new comes in
  always_comb begin : p_issue
    issue_req_d   = '0;
    issue_valid_d = 1'b0;
    if (hold) begin
      issue_req_d   = issue_req_q;
      issue_valid_d = 1'b1;
    end else if (accept_o) begin
      issue_req_d = '{
        id        : new_id_i,
        op        : req_i.op,
        unit      : req_unit,
        vd        : req_i.vd,
        vs1       : req_i.vs1,
        vs2       : req_i.vs2,
        use_vd    : req_i.use_vd,
        use_vs1   : req_i.use_vs1,
        use_vs2   : req_i.use_vs2,
        hazard_vs1: hazard_vs1_i,
        hazard_vs2: hazard_vs2_i,
        hazard_vd : hazard_vd_i
      };
      issue_valid_d = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Global hazard table
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_table
    hazard_table_d = hazard_table_q;
    // New row lists every producer of the new instruction
    if (accept_o) begin
      hazard_table_d[new_id_i] = hazard_vs1_i | hazard_vs2_i | hazard_vd_i;
    end
    // Finished producers drop out of every row
    for (int unsigned r = 0; r < NrVInsn; r++) begin
      hazard_table_d[r] &= running_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_req_q    <= '0;
      issue_valid_q  <= 1'b0;
      hazard_table_q <= '0;
    end else begin
      issue_req_q    <= issue_req_d;
      issue_valid_q  <= issue_valid_d;
      hazard_table_q <= hazard_table_d;
    end
  end

  assign issue_req_o           = issue_req_q;
  assign issue_valid_o         = issue_valid_q;
  assign global_hazard_table_o = hazard_table_q;

  // Stalled request stays put until the units take it
  a_hold_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue_valid_q && !issue_ready_i) |=> (issue_valid_q && $stable(issue_req_q)))
    else $error("Issued request changed under back-pressure");

  // The allocator must never offer an ID that is still in flight
  a_new_id_free : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept_o |-> !running_i[new_id_i])
    else $error("Accepted with busy ID %0d", new_id_i);

endmodule

//--- verilog/seq_pkg.sv
// Shared types and constants for the vector instruction sequencer.
// Every sequencer block imports this package for its IDs, register
// indices, opcode and unit encodings, and request structs

package seq_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Instructions that may be in flight at once
  localparam int unsigned NrVInsn = 8;
  // Architectural vector registers
  localparam int unsigned NrVRegs = 32;
  // Functional units behind the sequencer
  localparam int unsigned NrUnits = 4;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  // One bit per instruction ID
  typedef logic [NrVInsn-1:0]         vid_mask_t;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_MUL,
    UNIT_LOAD,
    UNIT_STORE
  } unit_e;

  // Grouped by target unit
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_MUL,
    OP_MACC,
    OP_LOAD,
    OP_STORE
  } op_e;

  // Each opcode runs on exactly one unit
  function automatic unit_e unit_of(op_e op);
    unit_of = UNIT_STORE;
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_OR: unit_of = UNIT_ALU;
      OP_MUL, OP_MACC:               unit_of = UNIT_MUL;
      OP_LOAD:                       unit_of = UNIT_LOAD;
      default:                       unit_of = UNIT_STORE;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////

  // Decoded instruction from the dispatcher
  typedef struct packed {
    op_e   op;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    logic  use_vd;
    logic  use_vs1;
    logic  use_vs2;
  } seq_req_t;

  // Instruction as handed to the functional units
  typedef struct packed {
    vid_t      id;
    op_e       op;
    unit_e     unit;
    vreg_t     vd;
    vreg_t     vs1;
    vreg_t     vs2;
    logic      use_vd;
    logic      use_vs1;
    logic      use_vs2;
    vid_mask_t hazard_vs1;
    vid_mask_t hazard_vs2;
    vid_mask_t hazard_vd;
  } issue_req_t;

  typedef struct packed {
    logic valid;
    vid_t vid;
  } unit_done_entry_t;

  // Completion pulses, indexed by unit_e
  typedef struct packed {
    unit_done_entry_t [NrUnits-1:0] unit;
  } unit_done_t;

  // Row N lists the IDs that instruction N waits on
  typedef vid_mask_t [NrVInsn-1:0] hazard_table_t;

endpackage

//--- verilog/unit_queue_counters.sv
// Occupancy counters for the functional unit instruction queues.
// Each counter rises on an accept to its unit and falls on that unit's
// done pulse; the room flags gate new requests
`timescale 1ns/1ps

module unit_queue_counters import seq_pkg::*; #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Accepted instruction
  input  logic               accept_i,
  input  op_e                op_i,
  // Completion pulses from the units
  input  unit_done_t         unit_done_i,
  // Space left in each queue
  output logic [NrUnits-1:0] unit_room_o
);

  // Must hold the value QueueDepth itself
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  typedef logic [CntWidth-1:0] cnt_t;

  unit_e acc_unit;

  assign acc_unit = unit_of(op_i);

  for (genvar u = 0; u < NrUnits; u++) begin : gen_cnt
    cnt_t cnt_q;
    logic cnt_up;
    logic cnt_down;

    assign cnt_up   = accept_i && (acc_unit == unit_e'(u));
    assign cnt_down = unit_done_i.unit[u].valid;

    // Hold when one enters and one leaves in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (cnt_up && !cnt_down) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end else if (cnt_down && !cnt_up) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
    end

    assign unit_room_o[u] = (cnt_q < cnt_t'(QueueDepth));

    a_cnt_max : assert property (@(posedge clk_i) disable iff (!rst_ni)
      cnt_q <= cnt_t'(QueueDepth))
      else $error("Queue counter %0d above depth", u);

    a_cnt_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (cnt_down && !cnt_up) |-> (cnt_q != '0))
      else $error("Queue counter %0d underflow", u);
  end

endmodule

//--- verilog/vector_sequencer.sv
// Top level of the single-issue vector instruction sequencer.
// Connects the ID allocator, register tracker, queue counters and issue
// control between the dispatcher and the functional units
`timescale 1ns/1ps

module vector_sequencer import seq_pkg::*; #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  // Dispatcher
  input  seq_req_t      req_i,
  input  logic          req_valid_i,
  output logic          req_ready_o,
  // Functional units
  output issue_req_t    issue_req_o,
  output logic          issue_valid_o,
  input  logic          issue_ready_i,
  input  unit_done_t    unit_done_i,
  // Status
  output hazard_table_t global_hazard_table_o,
  output logic          idle_o
);

  logic               accept;
  vid_t               new_id;
  logic               id_full;
  vid_mask_t          running;
  logic [NrUnits-1:0] unit_room;
  vid_mask_t          hazard_vs1, hazard_vs2, hazard_vd;

  vid_allocator i_vid_allocator (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .alloc_i     (accept),
    .alloc_unit_i(unit_of(req_i.op)),
    .unit_done_i (unit_done_i),
    .next_id_o   (new_id),
    .full_o      (id_full),
    .running_o   (running),
    .idle_o      (idle_o)
  );

  vreg_tracker i_vreg_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .accept_i    (accept),
    .new_id_i    (new_id),
    .running_i   (running),
    .hazard_vs1_o(hazard_vs1),
    .hazard_vs2_o(hazard_vs2),
    .hazard_vd_o (hazard_vd)
  );

  unit_queue_counters #(
    .QueueDepth(QueueDepth)
  ) i_unit_queue_counters (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .accept_i   (accept),
    .op_i       (req_i.op),
    .unit_done_i(unit_done_i),
    .unit_room_o(unit_room)
  );

  issue_ctrl i_issue_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .req_i                (req_i),
    .req_valid_i          (req_valid_i),
    .req_ready_o          (req_ready_o),
    .accept_o             (accept),
    .new_id_i             (new_id),
    .id_full_i            (id_full),
    .unit_room_i          (unit_room),
    .running_i            (running),
    .hazard_vs1_i         (hazard_vs1),
    .hazard_vs2_i         (hazard_vs2),
    .hazard_vd_i          (hazard_vd),
    .issue_req_o          (issue_req_o),
    .issue_valid_o        (issue_valid_o),
    .issue_ready_i        (issue_ready_i),
    .global_hazard_table_o(global_hazard_table_o)
  );

endmodule

//--- verilog/vid_allocator.sv
// Instruction ID bookkeeping for the sequencer.
// Keeps a running bit per unit and ID, offers the lowest free ID to the
// issue logic and flags when nothing is in flight
`timescale 1ns/1ps

module vid_allocator import seq_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Allocation on an accepted instruction
  input  logic       alloc_i,
  input  unit_e      alloc_unit_i,
  // Completion pulses from the units
  input  unit_done_t unit_done_i,
  // ID offer and running state
  output vid_t       next_id_o,
  output logic       full_o,
  output vid_mask_t  running_o,
  output logic       idle_o
);

  // A set bit means the ID is running on that unit
  vid_mask_t [NrUnits-1:0] running_d, running_q;
  // Running anywhere
  vid_mask_t               running_all;

  always_comb begin : p_running
    running_d = running_q;
    // Retire finished instructions
    for (int unsigned u = 0; u < NrUnits; u++) begin
      if (unit_done_i.unit[u].valid) begin
        running_d[u][unit_done_i.unit[u].vid] = 1'b0;
      end
    end
    // Claim the offered ID on its target unit
    if (alloc_i) begin
      running_d[alloc_unit_i][next_id_o] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

  always_comb begin : p_running_all
    running_all = '0;
    for (int unsigned u = 0; u < NrUnits; u++) begin
      running_all |= running_q[u];
    end
  end

  // Lowest free ID wins, scan from the top so the last hit is the smallest
  always_comb begin : p_next_id
    next_id_o = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_all[i]) begin
        next_id_o = vid_t'(i);
      end
    end
  end

  assign full_o    = &running_all;
  assign idle_o    = ~|running_all;
  assign running_o = running_all;

  // A unit may only finish what it was given
  for (genvar u = 0; u < NrUnits; u++) begin : gen_done_check
    a_done_running : assert property (@(posedge clk_i) disable iff (!rst_ni)
      unit_done_i.unit[u].valid |-> running_q[u][unit_done_i.unit[u].vid])
      else $error("Done on unit %0d for idle ID %0d", u, unit_done_i.unit[u].vid);
  end

endmodule

//--- verilog/vreg_tracker.sv
// Vector register access lists for hazard detection.
// Records the last reader and writer ID of every register and compares an
// incoming instruction against them to form its RAW, WAR and WAW masks
`timescale 1ns/1ps

module vreg_tracker import seq_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Incoming instruction and its acceptance
  input  seq_req_t  req_i,
  input  logic      accept_i,
  input  vid_t      new_id_i,
  // IDs still in flight
  input  vid_mask_t running_i,
  // Dependencies of the incoming instruction
  output vid_mask_t hazard_vs1_o,
  output vid_mask_t hazard_vs2_o,
  output vid_mask_t hazard_vd_o
);

  // Last instruction touching a register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  vreg_access_t [NrVRegs-1:0] read_list_d, read_list_q;
  vreg_access_t [NrVRegs-1:0] write_list_d, write_list_q;

  // Entry is valid and its owner has not finished yet
  logic [NrVRegs-1:0] rd_live, wr_live;

  always_comb begin : p_live
    for (int unsigned v = 0; v < NrVRegs; v++) begin
      rd_live[v] = read_list_q[v].valid & running_i[read_list_q[v].vid];
      wr_live[v] = write_list_q[v].valid & running_i[write_list_q[v].vid];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Hazards
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_hazard
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    hazard_vd_o  = '0;
    // RAW on the sources
    if (req_i.use_vs1 && wr_live[req_i.vs1]) begin
      hazard_vs1_o[write_list_q[req_i.vs1].vid] = 1'b1;
    end
    if (req_i.use_vs2 && wr_live[req_i.vs2]) begin
      hazard_vs2_o[write_list_q[req_i.vs2].vid] = 1'b1;
    end
    // WAR and WAW share the destination mask
    if (req_i.use_vd) begin
      if (rd_live[req_i.vd]) begin
        hazard_vd_o[read_list_q[req_i.vd].vid] = 1'b1;
      end
      if (wr_live[req_i.vd]) begin
        hazard_vd_o[write_list_q[req_i.vd].vid] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Access list update
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_lists
    // Drop entries whose owner has retired
    for (int unsigned v = 0; v < NrVRegs; v++) begin
      read_list_d[v]  = '{vid: read_list_q[v].vid, valid: rd_live[v]};
      write_list_d[v] = '{vid: write_list_q[v].vid, valid: wr_live[v]};
    end
    // New instruction becomes the latest writer and reader
    if (accept_i) begin
      if (req_i.use_vd) begin
        write_list_d[req_i.vd] = '{vid: new_id_i, valid: 1'b1};
      end
      if (req_i.use_vs1) begin
        read_list_d[req_i.vs1] = '{vid: new_id_i, valid: 1'b1};
      end
      if (req_i.use_vs2) begin
        read_list_d[req_i.vs2] = '{vid: new_id_i, valid: 1'b1};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_list_q  <= '0;
      write_list_q <= '0;
    end else begin
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
    end
  end

endmodule
